// File: files.f
+incdir+include
hdl/qnet_pkg.sv
hdl/qnet_ifs.sv
hdl/qnet_cmd_capture.sv
hdl/qnet_cmd_engine.sv
hdl/qnet_tx_framer.sv
hdl/qnet_node.sv
verif/qnet_node_assert.sv
verif/qnet_node_checker.sv
verif/qnet_node_tb.sv

// File: hdl/qnet_cmd_capture.sv
`include "qnet_defines.svh"

module qnet_cmd_capture (
   input  logic                 t_clk,
   input  logic                 init_aresetn,
   input  logic                 cmd_i,
   input  logic [4:0]           op_i,
   input  logic [`QNET_DW-1:0]  dt1_i,
   input  logic [`QNET_DW-1:0]  dt2_i,
   input  logic [`QNET_DW-1:0]  dt3_i,
   input  logic                 rx_valid_i,
   input  logic [`QNET_FW-1:0]  rx_data_i,
   input  logic                 rx_last_i,
   qnet_cmd_if.src              cmd,
   output logic                 local_busy_o
);

   logic                  loc_full;
   qnet_pkg::qnet_hdr_t   loc_hdr_new;
   qnet_pkg::qnet_hdr_t   loc_hdr;
   logic [`QNET_DW-1:0]   loc_dt0;
   logic [`QNET_DW-1:0]   loc_dt1;
   logic                  rx_hdr_vld;
   qnet_pkg::qnet_hdr_t   rx_hdr;
   logic                  net_fill;
   logic                  net_full;
   qnet_pkg::qnet_hdr_t   net_hdr;
   logic [`QNET_DW-1:0]   net_dt0;
   logic [`QNET_DW-1:0]   net_dt1;
   logic                  loc_ack;
   logic                  net_ack;

   // Ack goes to whichever slot is on the interface
   assign loc_ack = cmd.ack & loc_full;
   assign net_ack = cmd.ack & ~loc_full & net_full;

   ////////////////////////////////////////
   // Local slot
   ////////////////////////////////////////

   // Engine fills in cfg, flg and src
   always_comb begin
      loc_hdr_new     = '0;
      loc_hdr_new.id  = qnet_pkg::qnet_op_e'(op_i);
      loc_hdr_new.dst = dt3_i[`QNET_IDW-1:0];
   end

   always_ff @(posedge t_clk or negedge init_aresetn) begin
      if (!init_aresetn) begin
         loc_full <= 1'b0;
      end else if (cmd_i) begin
         loc_full <= 1'b1;
      end else if (loc_ack) begin
         loc_full <= 1'b0;
      end
   end

   always_ff @(posedge t_clk) begin
      if (cmd_i) begin
         loc_hdr <= loc_hdr_new;
         loc_dt0 <= dt1_i;
         loc_dt1 <= dt2_i;
      end
   end

   ////////////////////////////////////////
   // Net slot
   ////////////////////////////////////////

   // Full frame with nowhere to go is lost
   assign net_fill = rx_valid_i & rx_last_i & rx_hdr_vld & ~net_full;

   always_ff @(posedge t_clk or negedge init_aresetn) begin
      if (!init_aresetn) begin
         rx_hdr_vld <= 1'b0;
         net_full   <= 1'b0;
      end else begin
         if (rx_valid_i) begin
            rx_hdr_vld <= ~rx_last_i;
         end
         if (net_fill) begin
            net_full <= 1'b1;
         end else if (net_ack) begin
            net_full <= 1'b0;
         end
      end
   end

   always_ff @(posedge t_clk) begin
      if (rx_valid_i && !rx_last_i) begin
         rx_hdr <= qnet_pkg::qnet_hdr_t'(rx_data_i);
      end
      if (net_fill) begin
         net_hdr <= rx_hdr;
         net_dt0 <= rx_data_i[`QNET_DW-1:0];
         net_dt1 <= rx_data_i[`QNET_FW-1:`QNET_DW];
      end
   end

   // Local command wins
   assign cmd.req    = loc_full | net_full;
   assign cmd.is_net = ~loc_full;
   assign cmd.hdr    = loc_full ? loc_hdr : net_hdr;
   assign cmd.dt0    = loc_full ? loc_dt0 : net_dt0;
   assign cmd.dt1    = loc_full ? loc_dt1 : net_dt1;

   assign local_busy_o = loc_full;

endmodule

// File: hdl/qnet_cmd_engine.sv
`include "qnet_defines.svh"

module qnet_cmd_engine (
   input  logic                  t_clk,
   input  logic                  init_aresetn,
   qnet_cmd_if.sink              cmd,
   qnet_tx_if.src                tx,
   input  logic                  local_busy_i,
   output logic                  ready_o,
   output logic                  time_updt_o,
   output logic                  error_o,
   output logic [`QNET_DW-1:0]   time_off_dt_o,
   output logic [`QNET_DW-1:0]   tnet_dt1_o,
   output logic [`QNET_DW-1:0]   tnet_dt2_o,
   output logic [`QNET_IDW-1:0]  node_id_o,
   output logic [`QNET_IDW-1:0]  node_cnt_o
);

   qnet_pkg::eng_state_e   state;
   qnet_pkg::eng_state_e   state_nxt;
   logic                   exec;
   logic                   src_hit;
   logic                   dst_hit;
   logic                   send;
   qnet_pkg::qnet_hdr_t    out_hdr;
   logic [`QNET_FW-1:0]    out_data;
   logic                   upd_net;
   logic [`QNET_IDW-1:0]   new_id;
   logic [`QNET_IDW-1:0]   new_cnt;
   logic                   upd_dt;
   logic                   upd_off;
   logic                   bad_op;
   qnet_pkg::qnet_hdr_t    tx_hdr_r;
   logic [`QNET_FW-1:0]    tx_data_r;

   assign exec    = (state == qnet_pkg::EXEC);
   assign src_hit = (cmd.hdr.src == node_id_o);
   assign dst_hit = (cmd.hdr.dst == node_id_o);

   ////////////////////////////////////////
   // Command decode
   ////////////////////////////////////////

   always_comb begin
      send     = 1'b0;
      out_hdr  = cmd.hdr;
      out_data = {cmd.dt1, cmd.dt0};
      upd_net  = 1'b0;
      new_id   = '0;
      new_cnt  = '0;
      upd_dt   = 1'b0;
      upd_off  = 1'b0;
      bad_op   = 1'b0;
      if (!cmd.is_net) begin
         // Local request, always goes out
         send         = 1'b1;
         out_hdr.cfg  = `QNET_CFG;
         out_hdr.flg  = `QNET_FLG_REQ;
         out_hdr.src  = node_id_o;
         out_hdr.step = '0;
         out_hdr.id0  = '0;
         out_hdr.id1  = '0;
         if (cmd.hdr.id == qnet_pkg::set_net) begin
            // dt3 rides in the dst field
            out_hdr.dst = `QNET_BCAST;
            out_hdr.src = `QNET_IDW'(1);
            out_hdr.id0 = cmd.hdr.dst;
            out_hdr.id1 = `QNET_IDW'(2);
            upd_net     = 1'b1;
            new_id      = `QNET_IDW'(1);
            new_cnt     = cmd.hdr.dst;
         end
      end else if (!src_hit) begin
         // Own frames back from the ring are dropped
         case (cmd.hdr.id)
            qnet_pkg::set_net: begin
               upd_net     = 1'b1;
               new_id      = cmd.hdr.id1;
               new_cnt     = cmd.hdr.id0;
               send        = 1'b1;
               out_hdr.id1 = cmd.hdr.id1 + 1'b1;
            end
            qnet_pkg::set_dt: begin
               if (dst_hit) begin
                  upd_dt = 1'b1;
               end else begin
                  send = 1'b1;
               end
            end
            qnet_pkg::get_dt: begin
               if (dst_hit && cmd.hdr.flg[0]) begin
                  upd_dt = 1'b1;
               end else if (dst_hit) begin
                  // Answer back to the requester
                  send        = 1'b1;
                  out_hdr     = '0;
                  out_hdr.cfg = `QNET_CFG;
                  out_hdr.id  = qnet_pkg::get_dt;
                  out_hdr.flg = `QNET_FLG_ANS;
                  out_hdr.dst = cmd.hdr.src;
                  out_hdr.src = node_id_o;
                  out_data    = {tnet_dt2_o, tnet_dt1_o};
               end else begin
                  send = 1'b1;
               end
            end
            qnet_pkg::updt_off: begin
               upd_off = 1'b1;
               send    = 1'b1;
            end
            default: begin
               bad_op = 1'b1;
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // FSM
   ////////////////////////////////////////

   always_ff @(posedge t_clk or negedge init_aresetn) begin
      if (!init_aresetn) begin
         state <= qnet_pkg::IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         qnet_pkg::IDLE: begin
            if (cmd.req) begin
               state_nxt = qnet_pkg::EXEC;
            end
         end
         qnet_pkg::EXEC: begin
            state_nxt = send ? qnet_pkg::SEND : qnet_pkg::DONE;
         end
         qnet_pkg::SEND: begin
            if (!tx.busy) begin
               state_nxt = qnet_pkg::DONE;
            end
         end
         default: begin
            state_nxt = qnet_pkg::IDLE;
         end
      endcase
   end

   assign cmd.ack  = exec;
   assign tx.valid = (state == qnet_pkg::SEND) & ~tx.busy;
   assign tx.hdr   = tx_hdr_r;
   assign tx.data  = tx_data_r;
   assign ready_o  = (state == qnet_pkg::IDLE) & ~local_busy_i;

   // Node parameters, updated at the end of EXEC
   always_ff @(posedge t_clk or negedge init_aresetn) begin
      if (!init_aresetn) begin
         node_id_o     <= '0;
         node_cnt_o    <= '0;
         tnet_dt1_o    <= '0;
         tnet_dt2_o    <= '0;
         time_off_dt_o <= '0;
         time_updt_o   <= 1'b0;
         error_o       <= 1'b0;
      end else begin
         if (exec && upd_net) begin
            node_id_o  <= new_id;
            node_cnt_o <= new_cnt;
         end
         if (exec && upd_dt) begin
            tnet_dt1_o <= cmd.dt0;
            tnet_dt2_o <= cmd.dt1;
         end
         if (exec && upd_off) begin
            time_off_dt_o <= cmd.dt0;
         end
         time_updt_o <= exec & upd_off;
         error_o     <= exec & bad_op;
      end
   end

   // Frame waits here until the framer is free
   always_ff @(posedge t_clk) begin
      if (exec && send) begin
         tx_hdr_r  <= out_hdr;
         tx_data_r <= out_data;
      end
   end

endmodule

// File: hdl/qnet_ifs.sv
`include "qnet_defines.svh"

// One pending command, capture to engine
interface qnet_cmd_if;
   logic                  req;
   logic                  is_net;
   qnet_pkg::qnet_hdr_t   hdr;
   logic [`QNET_DW-1:0]   dt0;
   logic [`QNET_DW-1:0]   dt1;
   logic                  ack;

   modport src  (output req, is_net, hdr, dt0, dt1, input  ack);
   modport sink (input  req, is_net, hdr, dt0, dt1, output ack);
endinterface

// One outgoing frame, engine to framer
interface qnet_tx_if;
   logic                  valid;
   qnet_pkg::qnet_hdr_t   hdr;
   logic [`QNET_FW-1:0]   data;
   logic                  busy;

   modport src  (output valid, hdr, data, input  busy);
   modport sink (input  valid, hdr, data, output busy);
endinterface

// File: hdl/qnet_node.sv
`include "qnet_defines.svh"

module qnet_node (
   input  logic                  t_clk,
   input  logic                  init_aresetn,
   // Processor command
   input  logic                  cmd_i,
   input  logic [4:0]            op_i,
   input  logic [`QNET_DW-1:0]   dt1_i,
   input  logic [`QNET_DW-1:0]   dt2_i,
   input  logic [`QNET_DW-1:0]   dt3_i,
   // Ring receive
   input  logic                  rx_valid_i,
   input  logic [`QNET_FW-1:0]   rx_data_i,
   input  logic                  rx_last_i,
   // Ring transmit
   output logic [`QNET_FW-1:0]   tx_tdata_o,
   output logic                  tx_tvalid_o,
   output logic                  tx_tlast_o,
   input  logic                  tx_tready_i,
   // Node status
   output logic                  ready_o,
   output logic                  time_updt_o,
   output logic                  error_o,
   output logic [`QNET_DW-1:0]   time_off_dt_o,
   output logic [`QNET_DW-1:0]   tnet_dt1_o,
   output logic [`QNET_DW-1:0]   tnet_dt2_o,
   output logic [`QNET_IDW-1:0]  node_id_o,
   output logic [`QNET_IDW-1:0]  node_cnt_o
);

   logic local_busy;

   qnet_cmd_if cmd_if ();
   qnet_tx_if  tx_if ();

   qnet_cmd_capture qnet_cmd_capture_inst (
      .t_clk        (t_clk),
      .init_aresetn (init_aresetn),
      .cmd_i        (cmd_i),
      .op_i         (op_i),
      .dt1_i        (dt1_i),
      .dt2_i        (dt2_i),
      .dt3_i        (dt3_i),
      .rx_valid_i   (rx_valid_i),
      .rx_data_i    (rx_data_i),
      .rx_last_i    (rx_last_i),
      .cmd          (cmd_if.src),
      .local_busy_o (local_busy)
   );

   qnet_cmd_engine qnet_cmd_engine_inst (
      .t_clk         (t_clk),
      .init_aresetn  (init_aresetn),
      .cmd           (cmd_if.sink),
      .tx            (tx_if.src),
      .local_busy_i  (local_busy),
      .ready_o       (ready_o),
      .time_updt_o   (time_updt_o),
      .error_o       (error_o),
      .time_off_dt_o (time_off_dt_o),
      .tnet_dt1_o    (tnet_dt1_o),
      .tnet_dt2_o    (tnet_dt2_o),
      .node_id_o     (node_id_o),
      .node_cnt_o    (node_cnt_o)
   );

   qnet_tx_framer qnet_tx_framer_inst (
      .t_clk        (t_clk),
      .init_aresetn (init_aresetn),
      .tx           (tx_if.sink),
      .tx_tdata_o   (tx_tdata_o),
      .tx_tvalid_o  (tx_tvalid_o),
      .tx_tlast_o   (tx_tlast_o),
      .tx_tready_i  (tx_tready_i)
   );

endmodule

// File: hdl/qnet_pkg.sv
`include "qnet_defines.svh"

package qnet_pkg;

   ////////////////////////////////////////
   // Opcodes
   ////////////////////////////////////////

   typedef enum logic [4:0] {
      set_net  = 5'b00010,
      updt_off = 5'b01001,
      set_dt   = 5'b01010,
      get_dt   = 5'b01011
   } qnet_op_e;

   // Command engine FSM
   typedef enum logic [1:0] {
      IDLE,
      EXEC,
      SEND,
      DONE
   } eng_state_e;

   ////////////////////////////////////////
   // Network header, MSB first
   ////////////////////////////////////////

   typedef struct packed {
      logic [2:0]           cfg;
      qnet_op_e             id;
      logic [5:0]           flg;
      logic [`QNET_IDW-1:0] dst;
      logic [`QNET_IDW-1:0] src;
      logic [`QNET_IDW-1:0] step;
      // Node count on set_net
      logic [`QNET_IDW-1:0] id0;
      // Next node ID on set_net
      logic [`QNET_IDW-1:0] id1;
   } qnet_hdr_t;

endpackage

// File: hdl/qnet_tx_framer.sv
`include "qnet_defines.svh"

module qnet_tx_framer (
   input  logic                 t_clk,
   input  logic                 init_aresetn,
   qnet_tx_if.sink              tx,
   output logic [`QNET_FW-1:0]  tx_tdata_o,
   output logic                 tx_tvalid_o,
   output logic                 tx_tlast_o,
   input  logic                 tx_tready_i
);

   qnet_pkg::qnet_hdr_t   hdr_r;
   logic [`QNET_FW-1:0]   data_r;
   // Low on the header beat, high on the data beat
   logic                  beat;
   logic                  accept;

   assign accept = tx_tvalid_o & tx_tready_i;

   always_ff @(posedge t_clk or negedge init_aresetn) begin
      if (!init_aresetn) begin
         tx_tvalid_o <= 1'b0;
         beat        <= 1'b0;
      end else if (tx.valid) begin
         tx_tvalid_o <= 1'b1;
         beat        <= 1'b0;
      end else if (accept) begin
         if (beat) begin
            tx_tvalid_o <= 1'b0;
            beat        <= 1'b0;
         end else begin
            beat <= 1'b1;
         end
      end
   end

   always_ff @(posedge t_clk) begin
      if (tx.valid) begin
         hdr_r  <= tx.hdr;
         data_r <= tx.data;
      end
   end

   ////////////////////////////////////////
   // Link side
   ////////////////////////////////////////

   assign tx_tdata_o = beat ? data_r : hdr_r;
   assign tx_tlast_o = tx_tvalid_o & beat;

   // Frame held until the last beat leaves
   assign tx.busy = tx_tvalid_o;

endmodule

// File: include/qnet_defines.svh
`ifndef QNET_DEFINES_SVH
`define QNET_DEFINES_SVH

////////////////////////////////////////
// Widths
////////////////////////////////////////

// Data word
`define QNET_DW      32

// Link beat and network header
`define QNET_FW      64

// Node ID, node count and header ID fields
`define QNET_IDW     10

////////////////////////////////////////
// Header codes
////////////////////////////////////////

// Config field of every header
`define QNET_CFG     3'b100

// Flags of a request frame
`define QNET_FLG_REQ 6'b100100

// Flags of an answer, bit 0 set
`define QNET_FLG_ANS 6'b000001

// Destination that every node accepts
`define QNET_BCAST   {`QNET_IDW{1'b1}}

`endif

// File: verif/qnet_node_assert.sv
`include "qnet_defines.svh"

module qnet_node_assert (
   input logic                 t_clk,
   input logic                 init_aresetn,
   input logic                 valid_i,
   input logic [`QNET_FW-1:0]  tx_tdata_i,
   input logic                 tx_tvalid_i,
   input logic                 tx_tlast_i,
   input logic                 tx_tready_i
);
   timeunit 1ns;
   timeprecision 1ps;

   logic frame_open;

   // Set by a new frame, cleared when its last beat leaves
   always_ff @(posedge t_clk or negedge init_aresetn) begin
      if (!init_aresetn) begin
         frame_open <= 1'b0;
      end else if (valid_i) begin
         frame_open <= 1'b1;
      end else if (tx_tvalid_i && tx_tready_i && tx_tlast_i) begin
         frame_open <= 1'b0;
      end
   end

   // Stalled beat holds
   assert property (@(posedge t_clk) disable iff (!init_aresetn)
      (tx_tvalid_i && !tx_tready_i) |=> (tx_tvalid_i && $stable(tx_tdata_i)))
      else $error("tx beat changed while tready was low");

   // Last beat follows an accepted header beat or its own stall
   assert property (@(posedge t_clk) disable iff (!init_aresetn)
      tx_tlast_i |-> ($past(tx_tvalid_i && tx_tready_i && !tx_tlast_i)
                      || $past(tx_tlast_i && !tx_tready_i)))
      else $error("tlast seen on the header beat");

   // Header accepted, data beat with tlast next
   assert property (@(posedge t_clk) disable iff (!init_aresetn)
      (tx_tvalid_i && tx_tready_i && !tx_tlast_i) |=> (tx_tvalid_i && tx_tlast_i))
      else $error("header beat not followed by the last beat");

   assert property (@(posedge t_clk) disable iff (!init_aresetn)
      valid_i |-> !frame_open)
      else $error("new frame offered while the framer was busy");

endmodule

bind qnet_tx_framer qnet_node_assert qnet_node_assert_inst (
   .t_clk        (t_clk),
   .init_aresetn (init_aresetn),
   .valid_i      (tx.valid),
   .tx_tdata_i   (tx_tdata_o),
   .tx_tvalid_i  (tx_tvalid_o),
   .tx_tlast_i   (tx_tlast_o),
   .tx_tready_i  (tx_tready_i)
);

// File: verif/qnet_node_checker.sv
`include "qnet_defines.svh"

module qnet_node_checker (
   input  logic                  t_clk,
   input  logic                  start_i,
   input  logic                  check_i,
   input  int                    test_i,
   input  logic                  exp_frame_i,
   input  logic [`QNET_FW-1:0]   exp_hdr_i,
   input  logic [`QNET_FW-1:0]   exp_data_i,
   input  logic [`QNET_IDW-1:0]  exp_id_i,
   input  logic [`QNET_IDW-1:0]  exp_cnt_i,
   input  logic [`QNET_DW-1:0]   exp_dt1_i,
   input  logic [`QNET_DW-1:0]   exp_dt2_i,
   input  logic [`QNET_DW-1:0]   exp_off_i,
   input  logic                  exp_err_i,
   input  logic                  exp_updt_i,
   input  logic                  cmd_i,
   input  logic                  ready_i,
   input  logic [`QNET_FW-1:0]   tx_tdata_i,
   input  logic                  tx_tvalid_i,
   input  logic                  tx_tlast_i,
   input  logic                  tx_tready_i,
   input  logic                  time_updt_i,
   input  logic                  error_i,
   input  logic [`QNET_DW-1:0]   time_off_dt_i,
   input  logic [`QNET_DW-1:0]   tnet_dt1_i,
   input  logic [`QNET_DW-1:0]   tnet_dt2_i,
   input  logic [`QNET_IDW-1:0]  node_id_i,
   input  logic [`QNET_IDW-1:0]  node_cnt_i,
   output int                    err_cnt_o
);
   timeunit 1ns;
   timeprecision 1ps;

   int                    errors = 0;
   int                    test_base = 0;
   int                    beats = 0;
   int                    updt_n = 0;
   int                    err_n = 0;
   logic                  cmd_q = 1'b0;
   logic [`QNET_FW-1:0]   hdr_got;
   logic [`QNET_FW-1:0]   data_got;

   assign err_cnt_o = errors;

   task automatic compare_value(input string name, input logic [63:0] got,
      input logic [63:0] exp);
      if (got !== exp) begin
         $display("[ERROR] test %0d %s: got %h expected %h", test_i, name, got, exp);
         errors++;
      end
   endtask

   task automatic report_test();
      if (exp_frame_i && beats == 0) begin
         $display("Test %0d: the expected frame was never sent", test_i);
         errors++;
      end else if (exp_frame_i && beats != 2) begin
         $display("Test %0d: frame had %0d beats instead of two", test_i, beats);
         errors++;
      end else if (!exp_frame_i && beats != 0) begin
         $display("Test %0d: %0d beats sent where no frame was expected", test_i, beats);
         errors++;
      end else if (exp_frame_i) begin
         compare_value("tx_tdata_o header", hdr_got, exp_hdr_i);
         compare_value("tx_tdata_o data", data_got, exp_data_i);
      end
      compare_value("node_id_o", 64'(node_id_i), 64'(exp_id_i));
      compare_value("node_cnt_o", 64'(node_cnt_i), 64'(exp_cnt_i));
      compare_value("tnet_dt1_o", 64'(tnet_dt1_i), 64'(exp_dt1_i));
      compare_value("tnet_dt2_o", 64'(tnet_dt2_i), 64'(exp_dt2_i));
      compare_value("time_off_dt_o", 64'(time_off_dt_i), 64'(exp_off_i));
      compare_value("time_updt_o pulses", 64'(updt_n), 64'(exp_updt_i));
      compare_value("error_o pulses", 64'(err_n), 64'(exp_err_i));
      if (errors == test_base) begin
         $display("Test %0d ok", test_i);
      end else begin
         $display("Test %0d failed with %0d errors", test_i, errors - test_base);
      end
   endtask

   ////////////////////////////////////////
   // Beat and pulse capture
   ////////////////////////////////////////

   always @(posedge t_clk) begin
      // Local command sits in its slot, node not ready
      if (cmd_q) begin
         compare_value("ready_o", 64'(ready_i), 64'h0);
      end
      cmd_q = cmd_i;
      if (start_i) begin
         beats     = 0;
         updt_n    = 0;
         err_n     = 0;
         test_base = errors;
      end else begin
         if (tx_tvalid_i && tx_tready_i) begin
            if (beats == 0) begin
               hdr_got = tx_tdata_i;
               if (tx_tlast_i) begin
                  $display("Test %0d: header beat was marked as last", test_i);
                  errors++;
               end
            end else begin
               data_got = tx_tdata_i;
               if (!tx_tlast_i) begin
                  $display("Test %0d: data beat was not marked as last", test_i);
                  errors++;
               end
            end
            beats++;
         end
         if (time_updt_i) begin
            updt_n++;
         end
         if (error_i) begin
            err_n++;
         end
      end
      if (check_i) begin
         report_test();
      end
   end

endmodule

// File: verif/qnet_node_tb.sv
`include "qnet_defines.svh"

module qnet_node_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_TESTS  = 11;
   localparam int MAX_CYCLES = 5 + 60 * NUM_TESTS;

   typedef struct packed {
      logic                  is_net;
      logic                  stall;
      logic [`QNET_FW-1:0]   in_hdr;
      logic [`QNET_FW-1:0]   in_data;
      logic                  exp_frame;
      logic [`QNET_FW-1:0]   exp_hdr;
      logic [`QNET_FW-1:0]   exp_data;
      logic [`QNET_IDW-1:0]  exp_id;
      logic [`QNET_IDW-1:0]  exp_cnt;
      logic [`QNET_DW-1:0]   exp_dt1;
      logic [`QNET_DW-1:0]   exp_dt2;
      logic [`QNET_DW-1:0]   exp_off;
      logic                  exp_err;
      logic                  exp_updt;
   } entry_t;

   logic                  t_clk = 1'b0;
   logic                  init_aresetn;
   logic                  cmd_i;
   logic [4:0]            op_i;
   logic [`QNET_DW-1:0]   dt1_i;
   logic [`QNET_DW-1:0]   dt2_i;
   logic [`QNET_DW-1:0]   dt3_i;
   logic                  rx_valid_i;
   logic [`QNET_FW-1:0]   rx_data_i;
   logic                  rx_last_i;
   logic [`QNET_FW-1:0]   tx_tdata_o;
   logic                  tx_tvalid_o;
   logic                  tx_tlast_o;
   logic                  tx_tready_i;
   logic                  ready_o;
   logic                  time_updt_o;
   logic                  error_o;
   logic [`QNET_DW-1:0]   time_off_dt_o;
   logic [`QNET_DW-1:0]   tnet_dt1_o;
   logic [`QNET_DW-1:0]   tnet_dt2_o;
   logic [`QNET_IDW-1:0]  node_id_o;
   logic [`QNET_IDW-1:0]  node_cnt_o;

   logic                  start;
   logic                  check;
   logic                  stall_en;
   int                    cur_test;
   entry_t                cur;
   int                    err_cnt;
   int                    cycles = 0;
   integer                seed = 32'hacd163b4;
   integer                rnd;
   entry_t                tbl [NUM_TESTS];

   always #50 t_clk = ~t_clk;

   qnet_node qnet_node_inst (.*);

   qnet_node_checker node_checker_inst (
      .t_clk         (t_clk),
      .start_i       (start),
      .check_i       (check),
      .test_i        (cur_test),
      .exp_frame_i   (cur.exp_frame),
      .exp_hdr_i     (cur.exp_hdr),
      .exp_data_i    (cur.exp_data),
      .exp_id_i      (cur.exp_id),
      .exp_cnt_i     (cur.exp_cnt),
      .exp_dt1_i     (cur.exp_dt1),
      .exp_dt2_i     (cur.exp_dt2),
      .exp_off_i     (cur.exp_off),
      .exp_err_i     (cur.exp_err),
      .exp_updt_i    (cur.exp_updt),
      .cmd_i         (cmd_i),
      .ready_i       (ready_o),
      .tx_tdata_i    (tx_tdata_o),
      .tx_tvalid_i   (tx_tvalid_o),
      .tx_tlast_i    (tx_tlast_o),
      .tx_tready_i   (tx_tready_i),
      .time_updt_i   (time_updt_o),
      .error_i       (error_o),
      .time_off_dt_i (time_off_dt_o),
      .tnet_dt1_i    (tnet_dt1_o),
      .tnet_dt2_i    (tnet_dt2_o),
      .node_id_i     (node_id_o),
      .node_cnt_i    (node_cnt_o),
      .err_cnt_o     (err_cnt)
   );

   // Random back-pressure on the link
   always @(negedge t_clk) begin
      rnd = $random(seed);
      if (stall_en) begin
         tx_tready_i = rnd[0];
      end else begin
         tx_tready_i = 1'b1;
      end
   end

   always @(posedge t_clk) begin
      cycles = cycles + 1;
      if (cycles > MAX_CYCLES) begin
         $display("Timeout after %0d cycles, test %0d never finished", cycles, cur_test);
         $display(">>> FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////

   // cfg and step are fixed for every frame in this table
   function automatic logic [`QNET_FW-1:0] pack_hdr(input logic [4:0] op,
      input logic [5:0] flg, input logic [9:0] dst, input logic [9:0] src,
      input logic [9:0] id0, input logic [9:0] id1);
      return {`QNET_CFG, op, flg, dst, src, 10'd0, id0, id1};
   endfunction

   function automatic entry_t make_entry(input logic is_net, input logic stall,
      input logic [63:0] in_hdr, input logic [63:0] in_data, input logic exp_frame,
      input logic [63:0] exp_hdr, input logic [63:0] exp_data, input logic [9:0] id,
      input logic [9:0] cnt, input logic [31:0] dt1, input logic [31:0] dt2,
      input logic [31:0] off, input logic err, input logic updt);
      return {is_net, stall, in_hdr, in_data, exp_frame, exp_hdr, exp_data,
              id, cnt, dt1, dt2, off, err, updt};
   endfunction

   task automatic fill_table();
      logic [63:0] h;
      // Local set_net with node count 5
      tbl[0] = make_entry(1'b0, 1'b0, pack_hdr(5'h02, 6'h00, 10'd5, 10'd0, 10'd0, 10'd0),
         64'hbbbb0001_aaaa0001, 1'b1,
         pack_hdr(5'h02, `QNET_FLG_REQ, `QNET_BCAST, 10'd1, 10'd5, 10'd2),
         64'hbbbb0001_aaaa0001, 10'd1, 10'd5, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
      tbl[1] = make_entry(1'b1, 1'b1,
         pack_hdr(5'h02, `QNET_FLG_REQ, `QNET_BCAST, 10'd7, 10'd8, 10'd3),
         64'h00000002_00000001, 1'b1,
         pack_hdr(5'h02, `QNET_FLG_REQ, `QNET_BCAST, 10'd7, 10'd8, 10'd4),
         64'h00000002_00000001, 10'd3, 10'd8, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
      // set_dt to this node, then to another one
      tbl[2] = make_entry(1'b1, 1'b0, pack_hdr(5'h0a, `QNET_FLG_REQ, 10'd3, 10'd7, 10'd0, 10'd0),
         64'h22222222_11111111, 1'b0, 64'h0, 64'h0,
         10'd3, 10'd8, 32'h11111111, 32'h22222222, 32'h0, 1'b0, 1'b0);
      h = pack_hdr(5'h0a, `QNET_FLG_REQ, 10'd5, 10'd7, 10'd0, 10'd0);
      tbl[3] = make_entry(1'b1, 1'b1, h, 64'h44444444_33333333, 1'b1, h, 64'h44444444_33333333,
         10'd3, 10'd8, 32'h11111111, 32'h22222222, 32'h0, 1'b0, 1'b0);
      // get_dt request answered with the stored words
      tbl[4] = make_entry(1'b1, 1'b1, pack_hdr(5'h0b, `QNET_FLG_REQ, 10'd3, 10'd6, 10'd0, 10'd0),
         64'h0, 1'b1, pack_hdr(5'h0b, `QNET_FLG_ANS, 10'd6, 10'd3, 10'd0, 10'd0),
         64'h22222222_11111111, 10'd3, 10'd8, 32'h11111111, 32'h22222222, 32'h0, 1'b0, 1'b0);
      tbl[5] = make_entry(1'b1, 1'b0, pack_hdr(5'h0b, `QNET_FLG_ANS, 10'd3, 10'd6, 10'd0, 10'd0),
         64'h66666666_55555555, 1'b0, 64'h0, 64'h0,
         10'd3, 10'd8, 32'h55555555, 32'h66666666, 32'h0, 1'b0, 1'b0);
      h = pack_hdr(5'h0b, `QNET_FLG_REQ, 10'd4, 10'd6, 10'd0, 10'd0);
      tbl[6] = make_entry(1'b1, 1'b1, h, 64'h0, 1'b1, h, 64'h0,
         10'd3, 10'd8, 32'h55555555, 32'h66666666, 32'h0, 1'b0, 1'b0);
      h = pack_hdr(5'h09, `QNET_FLG_REQ, `QNET_BCAST, 10'd6, 10'd0, 10'd0);
      tbl[7] = make_entry(1'b1, 1'b1, h, 64'hdead0000_00001234, 1'b1, h, 64'hdead0000_00001234,
         10'd3, 10'd8, 32'h55555555, 32'h66666666, 32'h1234, 1'b0, 1'b1);
      // Own frame back from the ring
      tbl[8] = make_entry(1'b1, 1'b0,
         pack_hdr(5'h09, `QNET_FLG_REQ, `QNET_BCAST, 10'd3, 10'd0, 10'd0),
         64'h00000000_00005678, 1'b0, 64'h0, 64'h0,
         10'd3, 10'd8, 32'h55555555, 32'h66666666, 32'h1234, 1'b0, 1'b0);
      tbl[9] = make_entry(1'b1, 1'b0, pack_hdr(5'h1f, `QNET_FLG_REQ, 10'd3, 10'd6, 10'd0, 10'd0),
         64'h0, 1'b0, 64'h0, 64'h0,
         10'd3, 10'd8, 32'h55555555, 32'h66666666, 32'h1234, 1'b1, 1'b0);
      tbl[10] = make_entry(1'b0, 1'b1, pack_hdr(5'h0b, 6'h00, 10'd9, 10'd0, 10'd0, 10'd0),
         64'h88888888_77777777, 1'b1,
         pack_hdr(5'h0b, `QNET_FLG_REQ, 10'd9, 10'd3, 10'd0, 10'd0),
         64'h88888888_77777777, 10'd3, 10'd8, 32'h55555555, 32'h66666666, 32'h1234, 1'b0, 1'b0);
   endtask

   ////////////////////////////////////////
   // Drive loop
   ////////////////////////////////////////

   // Engine back in IDLE and framer empty
   task automatic wait_idle();
      while (!(ready_o && !tx_tvalid_o)) begin
         @(negedge t_clk);
      end
   endtask

   task automatic apply_entry(input int idx);
      entry_t e;
      e = tbl[idx];
      wait_idle();
      cur_test = idx;
      cur      = e;
      stall_en = e.stall;
      start    = 1'b1;
      @(negedge t_clk);
      start = 1'b0;
      if (e.is_net) begin
         rx_valid_i = 1'b1;
         rx_data_i  = e.in_hdr;
         rx_last_i  = 1'b0;
         @(negedge t_clk);
         rx_data_i = e.in_data;
         rx_last_i = 1'b1;
         @(negedge t_clk);
         rx_valid_i = 1'b0;
         rx_last_i  = 1'b0;
      end else begin
         cmd_i = 1'b1;
         op_i  = e.in_hdr[60:56];
         // Only bits 9 to 0 of dt3 reach the header
         dt3_i = {22'h15a5a5, e.in_hdr[49:40]};
         dt1_i = e.in_data[31:0];
         dt2_i = e.in_data[63:32];
         @(negedge t_clk);
         cmd_i = 1'b0;
      end
      @(negedge t_clk);
      while (ready_o) begin
         @(negedge t_clk);
      end
      wait_idle();
      @(negedge t_clk);
      check = 1'b1;
      @(negedge t_clk);
      check = 1'b0;
   endtask

   initial begin
      init_aresetn = 1'b0;
      cmd_i        = 1'b0;
      op_i         = '0;
      dt1_i        = '0;
      dt2_i        = '0;
      dt3_i        = '0;
      rx_valid_i   = 1'b0;
      rx_data_i    = '0;
      rx_last_i    = 1'b0;
      tx_tready_i  = 1'b1;
      start        = 1'b0;
      check        = 1'b0;
      stall_en     = 1'b0;
      cur_test     = 0;
      cur          = '0;
      fill_table();
      repeat (5) @(negedge t_clk);
      init_aresetn = 1'b1;
      for (int i = 0; i < NUM_TESTS; i++) begin
         apply_entry(i);
      end
      repeat (2) @(negedge t_clk);
      $display("Tests run %0d, errors %0d", NUM_TESTS, err_cnt);
      if (err_cnt == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule
